//--- source/mult_pkg.sv
package mult_pkg;

    // Operand and result width
    localparam int operand_w = 32;

    // Accumulator, shifting multiplier and Booth guard bit
    localparam int prod_w = 2 * operand_w + 1;

    // Adder width covers an accumulator plus or minus two times the multiplicand
    localparam int acc_w = operand_w + 2;

    // Two multiplier bits retire per step
    localparam int step_count = operand_w / 2;

    // Counter holds 0 to step_count
    localparam int count_w = $clog2(step_count + 1);

    typedef enum logic [2:0] {
        booth_zero,
        booth_add1,
        booth_add2,
        booth_sub1,
        booth_sub2
    } booth_op_t;

    typedef enum logic [1:0] {
        seq_idle,
        seq_run,
        seq_done
    } seq_state_t;

    // Per-step control from sequencer to datapath
    typedef struct packed {
        logic first_op;
        logic write_en;
    } mult_step_t;

endpackage

//--- source/mult_sequencer.sv
`timescale 1ns/1ns

module mult_sequencer import mult_pkg::*; (
    input  logic       clock,
    input  logic       rst_n,
    input  logic       ctrl_mult,
    output mult_step_t step,
    output logic       result_rdy
);

    seq_state_t         state;
    seq_state_t         state_next;
    logic [count_w-1:0] count;
    logic               steps_done;
    logic               running;

    assign running    = (state == seq_run);
    assign steps_done = (count == count_w'(step_count));

    always_comb begin
        state_next = state;
        unique case (state)
            seq_idle: begin
                state_next = seq_idle;
            end
            seq_run: begin
                // One settle cycle after the last write before ready
                if (steps_done) begin
                    state_next = seq_done;
                end
            end
            seq_done: begin
                state_next = seq_done;
            end
            default: begin
                state_next = seq_idle;
            end
        endcase
        // A new start wins in every state
        if (ctrl_mult) begin
            state_next = seq_run;
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            state <= seq_idle;
            count <= '0;
        end else begin
            state <= state_next;
            if (ctrl_mult) begin
                count <= '0;
            end else if (running && !steps_done) begin
                count <= count + count_w'(1);
            end
        end
    end

    // Step 0 loads pattern and low bits straight from the multiplier port
    always_comb begin
        step.first_op = running && (count == '0);
        step.write_en = running && !steps_done;
    end

    assign result_rdy = (state == seq_done);

endmodule

//--- source/booth_datapath.sv
`timescale 1ns/1ns

module booth_datapath import mult_pkg::*; (
    input  logic                 clock,
    input  logic                 rst_n,
    input  mult_step_t           step,
    input  logic [operand_w-1:0] multiplicand,
    input  logic [operand_w-1:0] multiplier,
    output logic [operand_w-1:0] result,
    output logic                 overflow
);

    // Partial high word in [64:33], product and multiplier bits in [32:1], guard in [0]
    logic [prod_w-1:0]    prod;
    logic [prod_w-1:0]    prod_next;

    logic [2:0]           pattern;
    booth_op_t            booth_op;

    logic [operand_w-1:0] high_bits;
    logic [operand_w-1:0] low_bits;
    logic [acc_w-1:0]     acc;
    logic [acc_w-1:0]     mcand_ext;
    logic [acc_w-1:0]     mcand_dbl;
    logic [acc_w-1:0]     addend;
    logic [acc_w-1:0]     sum;

    // Booth pattern with a zero guard bit on the first step
    always_comb begin
        if (step.first_op) begin
            pattern = {multiplier[1:0], 1'b0};
        end else begin
            pattern = prod[2:0];
        end
    end

    always_comb begin
        booth_op = booth_zero;
        unique case (pattern)
            3'b000, 3'b111: begin
                booth_op = booth_zero;
            end
            3'b001, 3'b010: begin
                booth_op = booth_add1;
            end
            3'b011: begin
                booth_op = booth_add2;
            end
            3'b100: begin
                booth_op = booth_sub2;
            end
            3'b101, 3'b110: begin
                booth_op = booth_sub1;
            end
            default: begin
                booth_op = booth_zero;
            end
        endcase
    end

    // Sign-extended multiplicand and its double
    assign mcand_ext = {{(acc_w - operand_w){multiplicand[operand_w-1]}}, multiplicand};
    assign mcand_dbl = {mcand_ext[acc_w-2:0], 1'b0};

    always_comb begin
        unique case (booth_op)
            booth_add1: begin
                addend = mcand_ext;
            end
            booth_add2: begin
                addend = mcand_dbl;
            end
            booth_sub1: begin
                addend = -mcand_ext;
            end
            booth_sub2: begin
                addend = -mcand_dbl;
            end
            default: begin
                addend = '0;
            end
        endcase
    end

    assign high_bits = prod[prod_w-1:operand_w+1];

    // Accumulator starts from zero and later from the partial high word
    always_comb begin
        if (step.first_op) begin
            acc      = '0;
            low_bits = multiplier;
        end else begin
            acc      = {{(acc_w - operand_w){high_bits[operand_w-1]}}, high_bits};
            low_bits = prod[operand_w:1];
        end
    end

    assign sum = acc + addend;

    // Shift right by two
    // The top sum bit carries the sign and the lowest remaining bit becomes the guard
    assign prod_next = {sum, low_bits[operand_w-1:1]};

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            prod <= '0;
        end else if (step.write_en) begin
            prod <= prod_next;
        end
    end

    assign result = prod[operand_w:1];

    // Full product fits only if the high word is the sign extension of the result
    assign overflow = (high_bits != {operand_w{result[operand_w-1]}});

endmodule

//--- source/mult.sv
`timescale 1ns/1ns

module mult import mult_pkg::*; (
    input  logic                 clock,
    input  logic                 rst_n,
    input  logic                 ctrl_mult,
    input  logic [operand_w-1:0] multiplicand,
    input  logic [operand_w-1:0] multiplier,
    output logic [operand_w-1:0] result,
    output logic                 overflow,
    output logic                 result_rdy
);

    mult_step_t step;

    // Step counter and ready
    mult_sequencer i_sequencer (
        .clock      (clock),
        .rst_n      (rst_n),
        .ctrl_mult  (ctrl_mult),
        .step       (step),
        .result_rdy (result_rdy)
    );

    // Booth recoding, adder and product register
    booth_datapath i_datapath (
        .clock        (clock),
        .rst_n        (rst_n),
        .step         (step),
        .multiplicand (multiplicand),
        .multiplier   (multiplier),
        .result       (result),
        .overflow     (overflow)
    );

endmodule

//--- sim/mult_assert.sv
`timescale 1ns/1ns

module mult_assert import mult_pkg::*; (
    input logic clock,
    input logic rst_n,
    input logic ctrl_mult,
    input logic result_rdy
);

    localparam int latency = step_count + 1;

    // Edges since the last start saturate one past latency
    logic [count_w-1:0] since_start;
    logic               armed;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            since_start <= '0;
            armed       <= 1'b0;
        end else if (ctrl_mult) begin
            since_start <= '0;
            armed       <= 1'b1;
        end else if (armed && since_start <= count_w'(latency)) begin
            since_start <= since_start + count_w'(1);
        end
    end

    a_ready_low: assert property (@(posedge clock) disable iff (!rst_n)
        ctrl_mult |=> !result_rdy)
        else $error("result_rdy high the cycle after ctrl_mult");

    a_ready_latency: assert property (@(posedge clock) disable iff (!rst_n)
        (armed && since_start == count_w'(latency)) |-> $rose(result_rdy))
        else $error("result_rdy did not rise at the expected step");

    a_ready_hold: assert property (@(posedge clock) disable iff (!rst_n)
        (result_rdy && !ctrl_mult) |=> result_rdy)
        else $error("result_rdy fell without ctrl_mult");

endmodule

bind mult_sequencer mult_assert i_mult_assert (
    .clock      (clock),
    .rst_n      (rst_n),
    .ctrl_mult  (ctrl_mult),
    .result_rdy (result_rdy)
);

//--- sim/mult_tb.sv
`timescale 1ns/1ns

module mult_tb import mult_pkg::*; ();

    // About 50 operations of 18 to 20 cycles each plus margin
    localparam int cycle_limit = 2000;
    localparam int latency     = step_count + 1;
    localparam int ready_limit = 2 * latency;

    logic                 clock;
    logic                 rst_n;
    logic                 ctrl_mult;
    logic [operand_w-1:0] multiplicand;
    logic [operand_w-1:0] multiplier;
    logic [operand_w-1:0] result;
    logic                 overflow;
    logic                 result_rdy;

    int seed;
    int cycles = 0;
    int error_count;
    int test_count;
    int failed_tests;

    mult i_mult (
        .clock        (clock),
        .rst_n        (rst_n),
        .ctrl_mult    (ctrl_mult),
        .multiplicand (multiplicand),
        .multiplier   (multiplier),
        .result       (result),
        .overflow     (overflow),
        .result_rdy   (result_rdy)
    );

    initial begin
        clock = 1'b0;
        forever begin
            #20 clock = ~clock;
        end
    end

    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout after %0d cycles, the tests did not finish", cycles);
            $display(">>> FAIL");
            $finish;
        end
    end

    task automatic check_word(input string name, input logic [operand_w-1:0] expected,
                              input logic [operand_w-1:0] actual);
        if (actual !== expected) begin
            $display("mismatch at %0t: %s expected %h actual %h", $time, name, expected, actual);
            error_count++;
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("mismatch at %0t: %s expected %b actual %b", $time, name, expected, actual);
            error_count++;
        end
    endtask

    task automatic check_op(input string name, input booth_op_t expected,
                            input booth_op_t actual);
        if (actual !== expected) begin
            $display("mismatch at %0t: %s expected %s actual %s", $time, name,
                     expected.name(), actual.name());
            error_count++;
        end
    endtask

    // Full signed 64-bit product
    function automatic logic signed [2*operand_w-1:0] model_product(
        input logic [operand_w-1:0] a, input logic [operand_w-1:0] b);
        logic signed [2*operand_w-1:0] wide_a;
        logic signed [2*operand_w-1:0] wide_b;
        wide_a = {{operand_w{a[operand_w-1]}}, a};
        wide_b = {{operand_w{b[operand_w-1]}}, b};
        return wide_a * wide_b;
    endfunction

    function automatic logic model_overflow(input logic signed [2*operand_w-1:0] product);
        return product != {{operand_w{product[operand_w-1]}}, product[operand_w-1:0]};
    endfunction

    task automatic start_op(input logic [operand_w-1:0] a, input logic [operand_w-1:0] b);
        @(posedge clock);
        multiplicand <= a;
        multiplier   <= b;
        ctrl_mult    <= 1'b1;
        @(posedge clock);
        ctrl_mult <= 1'b0;
        @(negedge clock);
        check_flag("result_rdy", 1'b0, result_rdy);
    endtask

    // Counts edges after the one that took the pulse
    task automatic wait_ready(output int edges);
        edges = 0;
        while (!result_rdy && edges < ready_limit) begin
            @(posedge clock);
            edges++;
            @(negedge clock);
        end
        if (!result_rdy) begin
            $display("result_rdy never came within %0d cycles of the start", ready_limit);
            error_count++;
        end
    endtask

    task automatic check_product(input logic [operand_w-1:0] a, input logic [operand_w-1:0] b);
        logic signed [2*operand_w-1:0] product;
        product = model_product(a, b);
        check_word("result", product[operand_w-1:0], result);
        check_flag("overflow", model_overflow(product), overflow);
    endtask

    task automatic multiply_and_check(input logic [operand_w-1:0] a,
                                      input logic [operand_w-1:0] b);
        int edges;
        start_op(a, b);
        wait_ready(edges);
        if (result_rdy) begin
            check_product(a, b);
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        test_count++;
        if (error_count == errors_before) begin
            $display("test %s passed", name);
        end else begin
            failed_tests++;
            $display("test %s failed with %0d errors", name, error_count - errors_before);
        end
    endtask

    task automatic test_reset();
        int errors_before;
        errors_before = error_count;
        repeat (6) begin
            @(negedge clock);
            check_flag("result_rdy", 1'b0, result_rdy);
        end
        check_word("result", '0, result);
        check_flag("overflow", 1'b0, overflow);
        report_test("reset", errors_before);
    endtask

    task automatic test_small_products();
        int errors_before;
        errors_before = error_count;
        multiply_and_check(0, 0);
        multiply_and_check(0, 32'd12345);
        multiply_and_check(1, 32'd987654);
        multiply_and_check(-123, 1);
        multiply_and_check(-7, 9);
        multiply_and_check(-13, -11);
        multiply_and_check(32'd123, -456);
        report_test("small_products", errors_before);
    endtask

    task automatic test_overflow();
        int errors_before;
        errors_before = error_count;
        multiply_and_check(65536, 65536);
        multiply_and_check(32'h8000_0000, -1);
        multiply_and_check(32'h8000_0000, 1);
        multiply_and_check(-1, -1);
        multiply_and_check(46341, 46341);
        report_test("overflow", errors_before);
    endtask

    task automatic test_random();
        int                   errors_before;
        logic [operand_w-1:0] a;
        logic [operand_w-1:0] b;
        errors_before = error_count;
        repeat (30) begin
            a = $random(seed);
            b = $random(seed);
            multiply_and_check(a, b);
        end
        report_test("random", errors_before);
    endtask

    // Second pulse lands in the middle of the first run
    task automatic test_restart();
        int errors_before;
        int edges;
        errors_before = error_count;
        start_op(32'd1000, 32'd3000);
        repeat (8) @(posedge clock);
        start_op(-25, 32'd40000);
        wait_ready(edges);
        check_word("latency", latency, edges);
        if (result_rdy) begin
            check_product(-25, 32'd40000);
        end
        report_test("restart", errors_before);
    endtask

    task automatic test_latency();
        int errors_before;
        int edges;
        errors_before = error_count;
        start_op(32'd77, -5);
        wait_ready(edges);
        check_word("latency", latency, edges);
        repeat (10) begin
            @(negedge clock);
            check_flag("result_rdy", 1'b1, result_rdy);
        end
        check_product(32'd77, -5);
        start_op(-300, -301);
        wait_ready(edges);
        check_word("latency", latency, edges);
        check_product(-300, -301);
        report_test("latency", errors_before);
    endtask

    // First step decode with a zero guard bit
    task automatic test_decode();
        int                   errors_before;
        int                   k;
        logic [operand_w-1:0] b;
        booth_op_t            expected;
        int                   edges;
        errors_before = error_count;
        for (k = 0; k < 4; k++) begin
            b      = $random(seed);
            b[1:0] = k[1:0];
            case (k)
                0: expected = booth_zero;
                1: expected = booth_add1;
                2: expected = booth_sub2;
                default: expected = booth_sub1;
            endcase
            start_op(32'd19, b);
            check_op("booth_op", expected, i_mult.i_datapath.booth_op);
            wait_ready(edges);
            check_product(32'd19, b);
        end
        report_test("decode", errors_before);
    endtask

    initial begin
        seed         = 21101;
        error_count  = 0;
        test_count   = 0;
        failed_tests = 0;
        rst_n        = 1'b0;
        ctrl_mult    = 1'b0;
        multiplicand = '0;
        multiplier   = '0;
        repeat (4) @(posedge clock);
        rst_n <= 1'b1;
        test_reset();
        test_small_products();
        test_overflow();
        test_random();
        test_restart();
        test_latency();
        test_decode();
        $display("tests %0d, failed %0d, errors %0d", test_count, failed_tests, error_count);
        if (error_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

//--- all.f
source/mult_pkg.sv
source/mult_sequencer.sv
source/booth_datapath.sv
source/mult.sv
sim/mult_assert.sv
sim/mult_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= mult_tb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
PASS_TEXT ?= >>> PASS
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ns -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- '$(PASS_TEXT)'

clean:
	rm -rf $(BUILD_DIR)
